// File: hw/engine_filter_cond.sv
// Filter-condition engine top level with I/O registers, queues and submodules
`timescale 1ns/1ns
`default_nettype none

`include "filter_cond_macros.svh"

module engine_filter_cond (
    input  logic                               ap_clk,
    input  logic                               areset_filter_cond_engine,
    input  filter_cond_pkg::kernel_descriptor_t descriptor_in,
    input  filter_cond_pkg::config_word_t       config_word_in,
    input  filter_cond_pkg::memory_packet_t     response_engine_in,
    output logic                               response_engine_ready,
    input  logic [`FC_NUM_LANES-1:0]            lane_ready,
    input  logic                               request_control_ready,
    output filter_cond_pkg::memory_packet_t     request_engine_out,
    output filter_cond_pkg::memory_packet_t     request_control_out,
    output logic                               config_loaded,
    output logic                               done
);

    import filter_cond_pkg::*;

    // Registered inputs
    kernel_descriptor_t       descriptor_reg;
    config_word_t             config_word_reg;
    memory_packet_t           response_engine_reg;
    logic [`FC_NUM_LANES-1:0] lane_ready_reg;
    logic                     request_control_ready_reg;

    filter_cond_config_t cfg;
    packet_payload_t     in_pop_data;
    packet_payload_t     eval_out_data;
    packet_payload_t     pass_pop_data;
    packet_payload_t     fail_pop_data;

    // Queue controls
    logic in_empty;
    logic in_nearly_full;
    logic in_pop;
    logic pass_empty;
    logic pass_nearly_full;
    logic pass_push;
    logic pass_pop;
    logic fail_empty;
    logic fail_nearly_full;
    logic fail_push;
    logic fail_pop;

    logic lane_ready_sel;
    logic count_reached;
    logic done_next;

    // --------------------------------------------------
    // Input register stage
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_filter_cond_engine) begin
            descriptor_reg.valid      <= 1'b0;
            config_word_reg.valid     <= 1'b0;
            response_engine_reg.valid <= 1'b0;
            lane_ready_reg            <= '0;
            request_control_ready_reg <= 1'b0;
        end else begin
            descriptor_reg.valid      <= descriptor_in.valid;
            config_word_reg.valid     <= config_word_in.valid;
            response_engine_reg.valid <= response_engine_in.valid;
            lane_ready_reg            <= lane_ready;
            request_control_ready_reg <= request_control_ready;
        end
    end

    // Payload fields carry no reset
    always_ff @(posedge ap_clk) begin
        descriptor_reg.count        <= descriptor_in.count;
        config_word_reg.index       <= config_word_in.index;
        config_word_reg.data        <= config_word_in.data;
        response_engine_reg.payload <= response_engine_in.payload;
    end

    // --------------------------------------------------
    // Configuration and lane back-pressure
    // --------------------------------------------------
    filter_cond_config_loader u_config_loader (
        .ap_clk                    (ap_clk),
        .areset_filter_cond_engine (areset_filter_cond_engine),
        .config_word_in            (config_word_reg),
        .config_out                (cfg),
        .config_loaded             (config_loaded)
    );

    lane_backpressure_select u_lane_select (
        .ap_clk                    (ap_clk),
        .areset_filter_cond_engine (areset_filter_cond_engine),
        .lane_ready                (lane_ready_reg),
        .lane_sel                  (cfg.lane),
        .config_loaded             (config_loaded),
        .lane_ready_sel            (lane_ready_sel)
    );

    // --------------------------------------------------
    // Input queue and evaluator
    // --------------------------------------------------
    packet_fifo #(
        .payload_t (packet_payload_t),
        .DEPTH     (`FC_FIFO_DEPTH)
    ) u_in_fifo (
        .ap_clk                    (ap_clk),
        .areset_filter_cond_engine (areset_filter_cond_engine),
        .push                      (response_engine_reg.valid),
        .push_data                 (response_engine_reg.payload),
        .pop                       (in_pop),
        .pop_data                  (in_pop_data),
        .empty                     (in_empty),
        .nearly_full               (in_nearly_full)
    );

    filter_cond_evaluator u_evaluator (
        .ap_clk                    (ap_clk),
        .areset_filter_cond_engine (areset_filter_cond_engine),
        .descriptor_in             (descriptor_reg),
        .config_in                 (cfg),
        .config_loaded             (config_loaded),
        .in_data                   (in_pop_data),
        .in_empty                  (in_empty),
        .in_pop                    (in_pop),
        .pass_full                 (pass_nearly_full),
        .fail_full                 (fail_nearly_full),
        .pass_push                 (pass_push),
        .fail_push                 (fail_push),
        .out_data                  (eval_out_data),
        .count_reached             (count_reached)
    );

    // --------------------------------------------------
    // Output queues, engine then control
    // --------------------------------------------------
    packet_fifo #(
        .payload_t (packet_payload_t),
        .DEPTH     (`FC_FIFO_DEPTH)
    ) u_pass_fifo (
        .ap_clk                    (ap_clk),
        .areset_filter_cond_engine (areset_filter_cond_engine),
        .push                      (pass_push),
        .push_data                 (eval_out_data),
        .pop                       (pass_pop),
        .pop_data                  (pass_pop_data),
        .empty                     (pass_empty),
        .nearly_full               (pass_nearly_full)
    );

    packet_fifo #(
        .payload_t (packet_payload_t),
        .DEPTH     (`FC_FIFO_DEPTH)
    ) u_fail_fifo (
        .ap_clk                    (ap_clk),
        .areset_filter_cond_engine (areset_filter_cond_engine),
        .push                      (fail_push),
        .push_data                 (eval_out_data),
        .pop                       (fail_pop),
        .pop_data                  (fail_pop_data),
        .empty                     (fail_empty),
        .nearly_full               (fail_nearly_full)
    );

    // Drain on downstream ready levels
    assign pass_pop  = !pass_empty && lane_ready_sel;
    assign fail_pop  = !fail_empty && request_control_ready_reg;
    // Counted work finished and nothing left queued
    assign done_next = count_reached && in_empty && pass_empty && fail_empty;

    // --------------------------------------------------
    // Output register stage
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_filter_cond_engine) begin
            request_engine_out.valid  <= 1'b0;
            request_control_out.valid <= 1'b0;
            response_engine_ready     <= 1'b1;
            done                      <= 1'b0;
        end else begin
            request_engine_out.valid  <= pass_pop;
            request_control_out.valid <= fail_pop;
            response_engine_ready     <= !in_nearly_full;
            // Sticky until reset
            done                      <= done | done_next;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_engine_out.payload  <= pass_pop_data;
        request_control_out.payload <= fail_pop_data;
    end

endmodule : engine_filter_cond

`default_nettype wire

// File: hw/filter_cond_config_loader.sv
// Configuration loader that gathers operator, threshold and lane words into one register
`timescale 1ns/1ns
`default_nettype none

`include "filter_cond_macros.svh"

module filter_cond_config_loader (
    input  logic                               ap_clk,
    input  logic                               areset_filter_cond_engine,
    input  filter_cond_pkg::config_word_t       config_word_in,
    output filter_cond_pkg::filter_cond_config_t config_out,
    output logic                               config_loaded
);

    import filter_cond_pkg::*;

    // One seen bit per configuration field
    logic [`FC_CFG_WORDS-1:0] seen;
    logic [`FC_CFG_WORDS-1:0] word_hit;
    logic [`FC_CFG_WORDS-1:0] seen_next;

    // --------------------------------------------------
    // Index decode
    // --------------------------------------------------
    always_comb begin
        word_hit = '0;
        // Frozen once loaded, later words dropped
        if (config_word_in.valid && !config_loaded) begin
            word_hit[config_word_in.index] = 1'b1;
        end
    end

    assign seen_next = seen | word_hit;

    always_ff @(posedge ap_clk) begin
        if (areset_filter_cond_engine) begin
            seen          <= '0;
            config_loaded <= 1'b0;
        end else begin
            seen          <= seen_next;
            // Loaded the cycle after the last missing field lands
            config_loaded <= &seen_next;
        end
    end

    // --------------------------------------------------
    // Field capture
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        // Index 0 holds the operator
        if (word_hit[0]) begin
            config_out.op <= cond_op_e'(config_word_in.data[2:0]);
        end
        // Index 1 holds the threshold
        if (word_hit[1]) begin
            config_out.threshold <= config_word_in.data;
        end
        // Index 2 holds the destination lane
        if (word_hit[2]) begin
            config_out.lane <= config_word_in.data[`FC_LANE_W-1:0];
        end
    end

    // Index must address a real field
    a_index_range : assert property (@(posedge ap_clk) disable iff (areset_filter_cond_engine)
        config_word_in.valid |-> (config_word_in.index < `FC_CFG_WORDS));

endmodule : filter_cond_config_loader

`default_nettype wire

// File: hw/filter_cond_evaluator.sv
// Filter evaluator that compares queued packets, steers them to engine or control, and counts
`timescale 1ns/1ns
`default_nettype none

`include "filter_cond_macros.svh"

module filter_cond_evaluator (
    input  logic                                ap_clk,
    input  logic                                areset_filter_cond_engine,
    input  filter_cond_pkg::kernel_descriptor_t  descriptor_in,
    input  filter_cond_pkg::filter_cond_config_t config_in,
    input  logic                                config_loaded,
    input  filter_cond_pkg::packet_payload_t     in_data,
    input  logic                                in_empty,
    output logic                                in_pop,
    input  logic                                pass_full,
    input  logic                                fail_full,
    output logic                                pass_push,
    output logic                                fail_push,
    output filter_cond_pkg::packet_payload_t     out_data,
    output logic                                count_reached
);

    import filter_cond_pkg::*;

    logic                   cond_pass;
    logic [`FC_COUNT_W-1:0] expected_count;
    logic [`FC_COUNT_W-1:0] processed_count;

    // --------------------------------------------------
    // Condition
    // --------------------------------------------------
    always_comb begin
        case (config_in.op)
            eq:      cond_pass = (in_data.data == config_in.threshold);
            ne:      cond_pass = (in_data.data != config_in.threshold);
            lt:      cond_pass = (in_data.data <  config_in.threshold);
            gt:      cond_pass = (in_data.data >  config_in.threshold);
            le:      cond_pass = (in_data.data <= config_in.threshold);
            ge:      cond_pass = (in_data.data >= config_in.threshold);
            // Unknown encodings fail everything
            default: cond_pass = 1'b0;
        endcase
    end

    // Pop only with room in both outputs
    assign in_pop    = config_loaded && !in_empty && !pass_full && !fail_full;
    assign pass_push = in_pop && cond_pass;
    assign fail_push = in_pop && !cond_pass;
    // Packet leaves unchanged
    assign out_data  = in_data;

    // --------------------------------------------------
    // Completion count
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_filter_cond_engine) begin
            expected_count  <= '0;
            processed_count <= '0;
        end else begin
            if (descriptor_in.valid) begin
                expected_count <= descriptor_in.count;
            end
            if (in_pop) begin
                processed_count <= processed_count + 1'b1;
            end
        end
    end

    // Zero count never completes
    assign count_reached = (expected_count != '0) && (processed_count == expected_count);

    // No more packets popped than the descriptor announced
    a_count_bound : assert property (@(posedge ap_clk) disable iff (areset_filter_cond_engine)
        (in_pop && (expected_count != '0)) |-> (processed_count < expected_count));

endmodule : filter_cond_evaluator

`default_nettype wire

// File: hw/filter_cond_macros.svh
// Widths, queue depths, lane count and configuration word count for the filter engine
`ifndef FILTER_COND_MACROS_SVH
`define FILTER_COND_MACROS_SVH

// --------------------------------------------------
// Packet fields
// --------------------------------------------------
// Vertex id and data word
`define FC_VERTEX_W 16
`define FC_DATA_W 32

// Descriptor packet count
`define FC_COUNT_W 16

// --------------------------------------------------
// Downstream lanes
// --------------------------------------------------
`define FC_NUM_LANES 4
`define FC_LANE_W 2

// --------------------------------------------------
// Queues and configuration
// --------------------------------------------------
`define FC_FIFO_DEPTH 8
// Free slots held back for the input register and the registered ready level
`define FC_FIFO_SLACK 3
// Operator, threshold, lane
`define FC_CFG_WORDS 3

`endif

// File: hw/filter_cond_pkg.sv
// Packet, descriptor, configuration and operator types for the filter engine
`default_nettype none

`include "filter_cond_macros.svh"

package filter_cond_pkg;

    // --------------------------------------------------
    // Comparison operator, unsigned compare
    // --------------------------------------------------
    typedef enum logic [2:0] {
        eq = 3'd0,
        ne = 3'd1,
        lt = 3'd2,
        gt = 3'd3,
        le = 3'd4,
        ge = 3'd5
    } cond_op_e;

    // Vertex id plus data word
    typedef struct packed {
        logic [`FC_VERTEX_W-1:0] vertex_id;
        logic [`FC_DATA_W-1:0]   data;
    } packet_payload_t;

    // Engine responses and both request outputs
    typedef struct packed {
        logic            valid;
        packet_payload_t payload;
    } memory_packet_t;

    // Memory response carrying one configuration word
    typedef struct packed {
        logic                 valid;
        logic [1:0]           index;
        logic [`FC_DATA_W-1:0] data;
    } config_word_t;

    // Number of engine responses to expect
    typedef struct packed {
        logic                   valid;
        logic [`FC_COUNT_W-1:0] count;
    } kernel_descriptor_t;

    // Assembled configuration
    typedef struct packed {
        cond_op_e              op;
        logic [`FC_DATA_W-1:0] threshold;
        logic [`FC_LANE_W-1:0] lane;
    } filter_cond_config_t;

endpackage : filter_cond_pkg

`default_nettype wire

// File: hw/lane_backpressure_select.sv
// Ready-level selector for the configured downstream lane, registered
`timescale 1ns/1ns
`default_nettype none

`include "filter_cond_macros.svh"

module lane_backpressure_select (
    input  logic                    ap_clk,
    input  logic                    areset_filter_cond_engine,
    input  logic [`FC_NUM_LANES-1:0] lane_ready,
    input  logic [`FC_LANE_W-1:0]    lane_sel,
    input  logic                    config_loaded,
    output logic                    lane_ready_sel
);

    // --------------------------------------------------
    // Lane ready mux
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_filter_cond_engine) begin
            lane_ready_sel <= 1'b0;
        end else begin
            // Lane index is meaningless until configured
            lane_ready_sel <= config_loaded & lane_ready[lane_sel];
        end
    end

endmodule : lane_backpressure_select

`default_nettype wire

// File: hw/packet_fifo.sv
// Synchronous circular-buffer FIFO with a type-parameter payload and a nearly-full flag
`timescale 1ns/1ns
`default_nettype none

`include "filter_cond_macros.svh"

module packet_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `FC_FIFO_DEPTH
) (
    input  logic     ap_clk,
    input  logic     areset_filter_cond_engine,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t pop_data,
    output logic     empty,
    output logic     nearly_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage, no reset needed on payload
    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] free_slots;

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_filter_cond_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Wrap explicitly so any depth works
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Show-ahead read of the head entry
    assign pop_data    = mem[rd_ptr];
    assign free_slots  = CNT_W'(DEPTH) - count;
    assign empty       = (count == '0);
    // Flag early so writes already in flight still fit
    assign nearly_full = (free_slots <= CNT_W'(`FC_FIFO_SLACK));

    // --------------------------------------------------
    // Checks
    // --------------------------------------------------
    a_no_overflow : assert property (@(posedge ap_clk) disable iff (areset_filter_cond_engine)
        push |-> (free_slots != '0));

    a_no_underflow : assert property (@(posedge ap_clk) disable iff (areset_filter_cond_engine)
        pop |-> !empty);

endmodule : packet_fifo

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the filter engine testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module tb_engine_filter_cond -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat build.log; echo "build or run error"; exit 1; }
cat sim.log
grep -q "test failed" sim.log && exit 1 || exit 0

// File: src.f
+incdir+hw
+incdir+tests
hw/filter_cond_pkg.sv
hw/packet_fifo.sv
hw/filter_cond_config_loader.sv
hw/filter_cond_evaluator.sv
hw/lane_backpressure_select.sv
hw/engine_filter_cond.sv
tests/tb_engine_filter_cond.sv

// File: tests/filter_cond_model.svh
// Reference model with the filter rule and the expected engine and control queues
`ifndef FILTER_COND_MODEL_SVH
`define FILTER_COND_MODEL_SVH

// Expected requests in arrival order, one queue per output
packet_payload_t exp_pass_q[$];
packet_payload_t exp_fail_q[$];

// Unsigned compare of data against the threshold
function automatic logic cond_holds(input logic [2:0] op, input logic [`FC_DATA_W-1:0] data,
                                    input logic [`FC_DATA_W-1:0] threshold);
    case (op)
        eq:      return data == threshold;
        ne:      return data != threshold;
        lt:      return data < threshold;
        gt:      return data > threshold;
        le:      return data <= threshold;
        ge:      return data >= threshold;
        // Unused encodings never pass
        default: return 1'b0;
    endcase
endfunction

// Route one offered packet to the output it should leave from
function automatic void expect_packet(input packet_payload_t pkt, input logic [2:0] op,
                                      input logic [`FC_DATA_W-1:0] threshold);
    if (cond_holds(op, pkt.data, threshold)) begin
        exp_pass_q.push_back(pkt);
    end else begin
        exp_fail_q.push_back(pkt);
    end
endfunction

`endif

// File: tests/tb_engine_filter_cond.sv
// Testbench for the filter-condition engine with clock, reset, random stimulus and checks
`timescale 1ns/1ns
`default_nettype none

`include "filter_cond_macros.svh"

module tb_engine_filter_cond;

    import filter_cond_pkg::*;

    `include "filter_cond_model.svh"

    localparam int FILTER_PACKETS   = 200;
    localparam int PRESSURE_PACKETS = 120;
    localparam int TOTAL_PACKETS    = FILTER_PACKETS + PRESSURE_PACKETS;
    // Worst-case drain per packet plus setup margin
    localparam int CYCLE_LIMIT      = TOTAL_PACKETS * 40 + 200;

    logic                     ap_clk;
    logic                     areset_filter_cond_engine;
    kernel_descriptor_t       descriptor_in;
    config_word_t             config_word_in;
    memory_packet_t           response_engine_in;
    logic                     response_engine_ready;
    logic [`FC_NUM_LANES-1:0] lane_ready;
    logic                     request_control_ready;
    memory_packet_t           request_engine_out;
    memory_packet_t           request_control_out;
    logic                     config_loaded;
    logic                     done;

    // Active configuration as seen by the model
    logic [2:0]            cfg_op;
    logic [`FC_DATA_W-1:0] cfg_threshold;
    logic [`FC_LANE_W-1:0] cfg_lane;

    int         cycle_count = 0;
    int         error_count = 0;
    int         tests_passed = 0;
    int         tests_failed = 0;
    int         received_count = 0;
    int         pass_seen = 0;
    int         fail_seen = 0;
    bit         pressure_on = 1'b0;
    bit         done_seen = 1'b0;
    logic [2:0] lane_hist = '0;

    engine_filter_cond dut (
        .ap_clk                    (ap_clk),
        .areset_filter_cond_engine (areset_filter_cond_engine),
        .descriptor_in             (descriptor_in),
        .config_word_in            (config_word_in),
        .response_engine_in        (response_engine_in),
        .response_engine_ready     (response_engine_ready),
        .lane_ready                (lane_ready),
        .request_control_ready     (request_control_ready),
        .request_engine_out        (request_engine_out),
        .request_control_out       (request_control_out),
        .config_loaded             (config_loaded),
        .done                      (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #4 ap_clk = ~ap_clk;
    end

    // Run limit
    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    // Next edge plus drive delay, back-pressure toggles here
    task automatic wait_cycle();
        @(posedge ap_clk);
        #1;
        if (pressure_on) begin
            lane_ready            = 4'($urandom);
            request_control_ready = 1'($urandom);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        int errs;
        errs = error_count - errors_before;
        if (errs == 0) begin
            $display("%s: ok", name);
            tests_passed++;
        end else begin
            $display("%s: %0d errors", name, errs);
            tests_failed++;
        end
    endtask

    function automatic logic [`FC_DATA_W-1:0] config_data(input int idx, input logic [2:0] op,
            input logic [`FC_DATA_W-1:0] thr, input logic [`FC_LANE_W-1:0] lane);
        case (idx)
            0:       return {29'd0, op};
            1:       return thr;
            default: return {30'd0, lane};
        endcase
    endfunction

    task automatic send_config_word(input int idx, input logic [`FC_DATA_W-1:0] data);
        config_word_in.valid = 1'b1;
        config_word_in.index = 2'(idx);
        config_word_in.data  = data;
        wait_cycle();
        config_word_in.valid = 1'b0;
    endtask

    // Data close to the threshold so every outcome shows up
    function automatic packet_payload_t random_packet(input int seq);
        packet_payload_t pkt;
        pkt.vertex_id = 16'(seq);
        if ($urandom % 8 == 0) begin
            pkt.data = $urandom;
        end else begin
            pkt.data = cfg_threshold + ($urandom % 7) - 32'd3;
        end
        return pkt;
    endfunction

    // Source holds off while ready is low
    task automatic send_packet(input packet_payload_t pkt);
        while (!response_engine_ready) begin
            wait_cycle();
        end
        response_engine_in.valid   = 1'b1;
        response_engine_in.payload = pkt;
        expect_packet(pkt, cfg_op, cfg_threshold);
        wait_cycle();
        response_engine_in.valid = 1'b0;
    endtask

    task automatic drain_queues();
        while (exp_pass_q.size() != 0 || exp_fail_q.size() != 0) begin
            wait_cycle();
        end
    endtask

    task automatic compare_request(input bit engine_side, input packet_payload_t got);
        packet_payload_t exp;
        string           name;
        int              pending;
        name    = engine_side ? "request_engine_out.payload" : "request_control_out.payload";
        pending = engine_side ? exp_pass_q.size() : exp_fail_q.size();
        if (pending == 0) begin
            $display("%s carried a packet that was never expected", name);
            error_count++;
        end else begin
            if (engine_side) begin
                exp = exp_pass_q.pop_front();
            end else begin
                exp = exp_fail_q.pop_front();
            end
            if (got !== exp) begin
                $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
                error_count++;
            end
        end
        received_count++;
    endtask

    // --------------------------------------------------
    // Output monitor, sampled mid-cycle
    // --------------------------------------------------
    always @(negedge ap_clk) begin
        if (request_engine_out.valid) begin
            // Lane level three edges back feeds this strobe
            if (!lane_hist[2]) begin
                $display("engine request at cycle %0d without the configured lane ready",
                         cycle_count);
                error_count++;
            end
            compare_request(1'b1, request_engine_out.payload);
            pass_seen++;
        end
        if (request_control_out.valid) begin
            compare_request(1'b0, request_control_out.payload);
            fail_seen++;
        end
        if (done && (received_count < TOTAL_PACKETS || exp_pass_q.size() != 0
                     || exp_fail_q.size() != 0)) begin
            $display("done was high at cycle %0d with packets still outstanding", cycle_count);
            error_count++;
        end
        if (done_seen && !done) begin
            $display("done fell at cycle %0d after it had risen", cycle_count);
            error_count++;
        end
        done_seen = done_seen | done;
        lane_hist = {lane_hist[1:0], lane_ready[cfg_lane]};
    end

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        int order [3];
        int swap_idx;
        int tmp;
        int errs_start;
        void'($urandom(81));
        areset_filter_cond_engine = 1'b1;
        descriptor_in             = '0;
        config_word_in            = '0;
        response_engine_in        = '0;
        lane_ready                = '0;
        request_control_ready     = 1'b0;
        cfg_op                    = 3'($urandom % 6);
        cfg_threshold             = 32'h100 + ($urandom % 32'h10000);
        cfg_lane                  = 2'($urandom);
        repeat (4) @(posedge ap_clk);
        #1;
        areset_filter_cond_engine = 1'b0;

        // Reset state
        errs_start = error_count;
        check_bit("request_engine_out.valid", request_engine_out.valid, 1'b0);
        check_bit("request_control_out.valid", request_control_out.valid, 1'b0);
        check_bit("done", done, 1'b0);
        check_bit("config_loaded", config_loaded, 1'b0);
        check_bit("response_engine_ready", response_engine_ready, 1'b1);
        report_test("reset state", errs_start);

        // Configuration in shuffled order, one repeat before the last new word
        errs_start = error_count;
        order = '{0, 1, 2};
        for (int i = 2; i > 0; i--) begin
            swap_idx        = int'($urandom % (i + 1));
            tmp             = order[i];
            order[i]        = order[swap_idx];
            order[swap_idx] = tmp;
        end
        send_config_word(order[0], config_data(order[0], cfg_op, cfg_threshold, cfg_lane));
        wait_cycle();
        send_config_word(order[1], config_data(order[1], cfg_op, cfg_threshold, cfg_lane));
        send_config_word(order[0], config_data(order[0], cfg_op, cfg_threshold, cfg_lane));
        check_bit("config_loaded", config_loaded, 1'b0);
        send_config_word(order[2], config_data(order[2], cfg_op, cfg_threshold, cfg_lane));
        check_bit("config_loaded", config_loaded, 1'b0);
        wait_cycle();
        check_bit("config_loaded", config_loaded, 1'b1);
        // Late words must be ignored
        for (int i = 0; i < 3; i++) begin
            send_config_word(i, config_data(i, 3'((cfg_op + 3'd1) % 6), ~cfg_threshold,
                                            cfg_lane + 2'd1));
        end
        check_bit("config_loaded", config_loaded, 1'b1);
        report_test("configuration", errs_start);

        // Filtering with all downstream ready
        errs_start            = error_count;
        lane_ready            = '1;
        request_control_ready = 1'b1;
        descriptor_in.valid   = 1'b1;
        descriptor_in.count   = 16'(TOTAL_PACKETS);
        wait_cycle();
        descriptor_in.valid = 1'b0;
        for (int i = 0; i < FILTER_PACKETS; i++) begin
            send_packet(random_packet(i));
        end
        drain_queues();
        if (pass_seen == 0 || fail_seen == 0) begin
            $display("filtering did not exercise both the engine and the control output");
            error_count++;
        end
        report_test("filtering", errs_start);

        // Random lane and control back-pressure with source gaps
        errs_start  = error_count;
        pressure_on = 1'b1;
        for (int i = 0; i < PRESSURE_PACKETS; i++) begin
            if ($urandom % 4 == 0) begin
                wait_cycle();
            end
            send_packet(random_packet(FILTER_PACKETS + i));
        end
        drain_queues();
        pressure_on           = 1'b0;
        lane_ready            = '1;
        request_control_ready = 1'b1;
        report_test("back-pressure and lane selection", errs_start);

        // Done after the counted packets, then sticky
        errs_start = error_count;
        while (!done) begin
            wait_cycle();
        end
        if (received_count != TOTAL_PACKETS) begin
            $display("ERROR received_count got 0x%0h expected 0x%0h", received_count,
                     TOTAL_PACKETS);
            error_count++;
        end
        repeat (20) wait_cycle();
        check_bit("done", done, 1'b1);
        report_test("done", errs_start);

        $display("tests passed: %0d, tests with errors: %0d, total errors: %0d",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : tb_engine_filter_cond

`default_nettype wire
